// File: design/cdc_pkg.sv
package cdc_pkg;

	// width of one measurement value
	localparam int VALUE_BITS = 16;

	// width of one tag
	localparam int TAG_BITS = 4;

	// width of the pair sequence number
	localparam int SEQ_BITS = 8;

	// flops in every synchronizer chain
	// both req and ack paths use the same depth
	localparam int SYNC_STAGES = 2;

	// measurement payload carried by the value channel
	typedef logic [VALUE_BITS-1:0] value_t;

	// tag payload carried by the tag channel
	typedef logic [TAG_BITS-1:0] tag_t;

	// pair number attached to every output pair
	// wraps back to zero after the last code
	typedef logic [SEQ_BITS-1:0] seq_t;

endpackage

// File: design/cdc_export.sv
`timescale 1ns/1ps

// source half of a two-phase toggle crossing
// a payload is latched on stb while ready, then req is inverted
// ready returns once the toggled ack has come back through the synchronizer

module cdc_export #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     stb,
	input  payload_t data,
	input  logic     ack,
	output logic     ready,
	output logic     req,
	output payload_t xfer_data
);
	import cdc_pkg::*;

	// ack synchronizer chain, index 0 sees the foreign signal first
	logic [SYNC_STAGES-1:0] ack_sync;
	// ack as seen in this clock domain
	logic                   ack_s;
	// strobe accepted in this cycle
	logic                   accept;

	assign ack_s = ack_sync[SYNC_STAGES-1];

	// nothing outstanding when the returned ack matches req
	assign ready = (ack_s == req);

	// a strobe while busy is dropped
	assign accept = stb && ready;

	// bring ack over from the destination clock
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_sync <= '0;
		end else begin
			ack_sync <= {ack_sync[SYNC_STAGES-2:0], ack};
		end
	end

	// req toggles once per accepted payload
	// the toggle itself marks a new transfer, no level meaning
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req <= 1'b0;
		end else if (accept) begin
			req <= ~req;
		end
	end

	// outgoing payload register
	// loaded on the same edge that toggles req
	// the destination samples it only after req has crossed two flops,
	// so it is long settled by then
	always_ff @(posedge clk) begin
		if (accept) begin
			xfer_data <= data;
		end
	end

	// held constant until ready comes back
	// this is what makes the bus safe to sample in the other domain

endmodule

// File: design/cdc_import.sv
`timescale 1ns/1ps

// destination half of a two-phase toggle crossing
// req is synchronized, the payload copied into a one-entry hold,
// then ack is set equal to req so the source may send again
// the hold is presented with valid until take

module cdc_import #(
	parameter type payload_t = logic
) (
	input  logic     dst_clk,
	input  logic     arst_n,
	input  logic     req,
	input  payload_t xfer_data,
	input  logic     take,
	output logic     ack,
	output logic     valid,
	output payload_t data
);
	import cdc_pkg::*;

	// req synchronizer chain
	logic [SYNC_STAGES-1:0] req_sync;
	// req as seen in dst_clk domain
	logic                   req_s;
	// a toggle is waiting to be acknowledged
	logic                   pending;
	// hold is empty or emptied this cycle
	logic                   room;
	// copy the crossing bus into the hold
	logic                   capture;

	assign req_s = req_sync[SYNC_STAGES-1];

	assign pending = (req_s != ack);

	// taking and refilling in one cycle keeps full throughput
	assign room = !valid || take;

	// without room the toggle stays unanswered
	// so the exporter keeps ready low
	assign capture = pending && room;

	// bring req over from the source clock
	always_ff @(posedge dst_clk or negedge arst_n) begin
		if (!arst_n) begin
			req_sync <= '0;
		end else begin
			req_sync <= {req_sync[SYNC_STAGES-2:0], req};
		end
	end

	// ack follows req once the payload is safely held
	always_ff @(posedge dst_clk or negedge arst_n) begin
		if (!arst_n) begin
			ack <= 1'b0;
		end else if (capture) begin
			ack <= req_s;
		end
	end

	// hold occupancy
	// a capture wins over a take in the same cycle
	always_ff @(posedge dst_clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= 1'b0;
		end else if (capture) begin
			valid <= 1'b1;
		end else if (take) begin
			valid <= 1'b0;
		end
	end

	// one-entry hold
	// xfer_data has been stable since before req toggled
	always_ff @(posedge dst_clk) begin
		if (capture) begin
			data <= xfer_data;
		end
	end

endmodule

// File: design/pair_merge.sv
`timescale 1ns/1ps

// pairing stage in the destination domain
// joins the nth value with the nth tag and numbers the pair
// both channels are always taken together, which keeps the order

module pair_merge (
	input  logic           dst_clk,
	input  logic           arst_n,
	input  logic           value_valid,
	input  cdc_pkg::value_t value,
	input  logic           tag_valid,
	input  cdc_pkg::tag_t   tag,
	output logic           value_take,
	output logic           tag_take,
	output logic           out_stb,
	output cdc_pkg::value_t out_value,
	output cdc_pkg::tag_t   out_tag,
	output cdc_pkg::seq_t   out_seq
);
	import cdc_pkg::*;

	// both holds are full in this cycle
	logic fire;

	// number for the next emitted pair
	seq_t next_seq;

	// a pair forms only when both sides have something
	// one channel alone just waits in its hold
	assign fire = value_valid && tag_valid;

	// one take per side, always in the same cycle
	// each is a single pulse since valid drops right after
	// unless a fresh payload lands on the same edge
	assign value_take = fire;
	assign tag_take   = fire;

	// output strobe
	// high for exactly one dst_clk cycle per pair
	always_ff @(posedge dst_clk or negedge arst_n) begin
		if (!arst_n) begin
			out_stb <= 1'b0;
		end else begin
			out_stb <= fire;
		end
	end

	// sequence counter
	// wraps naturally at the seq_t width
	always_ff @(posedge dst_clk or negedge arst_n) begin
		if (!arst_n) begin
			next_seq <= '0;
		end else if (fire) begin
			next_seq <= next_seq + 1'b1;
		end
	end

	// sequence number of the pair on the output
	// first pair after reset carries zero
	always_ff @(posedge dst_clk or negedge arst_n) begin
		if (!arst_n) begin
			out_seq <= '0;
		end else if (fire) begin
			out_seq <= next_seq;
		end
	end

	// output payload registers
	// only meaningful while out_stb is high
	// kept between pairs, no need to clear them
	always_ff @(posedge dst_clk) begin
		if (fire) begin
			out_value <= value;
			out_tag   <= tag;
		end
	end

	// no back-pressure on the output side
	// the downstream consumer must accept every out_stb

endmodule

// File: design/cdc_bridge_top.sv
`timescale 1ns/1ps

// two-channel clock-domain bridge
// value and tag cross independently from clk to dst_clk
// then get paired and numbered in the destination domain

module cdc_bridge_top (
	input  logic           clk,
	input  logic           dst_clk,
	input  logic           arst_n,
	input  logic           value_stb,
	input  cdc_pkg::value_t value,
	input  logic           tag_stb,
	input  cdc_pkg::tag_t   tag,
	output logic           value_ready,
	output logic           tag_ready,
	output logic           out_stb,
	output cdc_pkg::value_t out_value,
	output cdc_pkg::tag_t   out_tag,
	output cdc_pkg::seq_t   out_seq
);
	import cdc_pkg::*;

	// value crossing
	logic   value_req;
	logic   value_ack;
	value_t value_xfer;

	// value hold in dst_clk domain
	logic   value_valid;
	value_t value_held;
	logic   value_take;

	// tag crossing
	logic   tag_req;
	logic   tag_ack;
	tag_t   tag_xfer;

	// tag hold in dst_clk domain
	logic   tag_valid;
	tag_t   tag_held;
	logic   tag_take;

	// source side of the value channel
	cdc_export #(
		.payload_t (value_t)
	) i_value_export (
		.clk       (clk),
		.arst_n    (arst_n),
		.stb       (value_stb),
		.data      (value),
		.ack       (value_ack),
		.ready     (value_ready),
		.req       (value_req),
		.xfer_data (value_xfer)
	);

	// destination side of the value channel
	cdc_import #(
		.payload_t (value_t)
	) i_value_import (
		.dst_clk   (dst_clk),
		.arst_n    (arst_n),
		.req       (value_req),
		.xfer_data (value_xfer),
		.take      (value_take),
		.ack       (value_ack),
		.valid     (value_valid),
		.data      (value_held)
	);

	// source side of the tag channel
	cdc_export #(
		.payload_t (tag_t)
	) i_tag_export (
		.clk       (clk),
		.arst_n    (arst_n),
		.stb       (tag_stb),
		.data      (tag),
		.ack       (tag_ack),
		.ready     (tag_ready),
		.req       (tag_req),
		.xfer_data (tag_xfer)
	);

	// destination side of the tag channel
	cdc_import #(
		.payload_t (tag_t)
	) i_tag_import (
		.dst_clk   (dst_clk),
		.arst_n    (arst_n),
		.req       (tag_req),
		.xfer_data (tag_xfer),
		.take      (tag_take),
		.ack       (tag_ack),
		.valid     (tag_valid),
		.data      (tag_held)
	);

	// join both channels into numbered pairs
	pair_merge i_pair_merge (
		.dst_clk     (dst_clk),
		.arst_n      (arst_n),
		.value_valid (value_valid),
		.value       (value_held),
		.tag_valid   (tag_valid),
		.tag         (tag_held),
		.value_take  (value_take),
		.tag_take    (tag_take),
		.out_stb     (out_stb),
		.out_value   (out_value),
		.out_tag     (out_tag),
		.out_seq     (out_seq)
	);

endmodule

// File: tests/cdc_import_props.sv
`timescale 1ns/1ps

// checks on one cdc_import hold, sampled on dst_clk
// bound into every instance, so both channels are covered

module cdc_import_props #(
	parameter type payload_t = logic
) (
	input logic     dst_clk,
	input logic     arst_n,
	input logic     req_s,
	input logic     ack,
	input logic     valid,
	input logic     take,
	input payload_t data
);

	// failures seen so far, read by the testbench at the end
	int assert_failures = 0;

	// a full hold that is not taken keeps its payload
	hold_kept_until_take: assert property (
		@(posedge dst_clk) disable iff (!arst_n)
		(valid && !take) |=> (valid && $stable(data))
	) else begin
		assert_failures++;
		$error("hold dropped or changed its payload before take");
	end

	// ack only moves to answer a pending req toggle
	ack_moves_only_when_pending: assert property (
		@(posedge dst_clk) disable iff (!arst_n)
		(req_s == ack) |=> $stable(ack)
	) else begin
		assert_failures++;
		$error("ack changed while synchronized req already matched it");
	end

	// the pairing stage only takes a full hold
	take_needs_valid: assert property (
		@(posedge dst_clk) disable iff (!arst_n)
		take |-> valid
	) else begin
		assert_failures++;
		$error("take pulsed while the hold was empty");
	end

endmodule

bind cdc_import cdc_import_props #(
	.payload_t (payload_t)
) i_import_props (
	.dst_clk (dst_clk),
	.arst_n  (arst_n),
	.req_s   (req_s),
	.ack     (ack),
	.valid   (valid),
	.take    (take),
	.data    (data)
);

// File: tests/cdc_bridge_tb.sv
`timescale 1ns/1ps

module cdc_bridge_tb;
	import cdc_pkg::*;

	// clock half periods, the two clocks drift against each other
	localparam time clk_half     = 20ns;
	localparam time dst_clk_half = 28ns;

	localparam int reset_cycles = 10;
	localparam int num_pairs    = 300;

	// worst case per pair plus a margin for the slow tag channel
	localparam int worst_cycles_per_pair = 40;
	localparam int timeout_cycles = num_pairs * worst_cycles_per_pair + 8000;

	// cycles allowed for the last pairs to come out
	localparam int drain_cycles = 400;

	// an uncongested round trip stays well under this
	localparam int free_stall_max = 12;

	localparam logic [31:0] rand_seed = 32'h8a53_fa44;

	logic   clk;
	logic   dst_clk;
	logic   arst_n;
	logic   value_stb;
	value_t value;
	logic   tag_stb;
	tag_t   tag;
	logic   value_ready;
	logic   tag_ready;
	logic   out_stb;
	value_t out_value;
	tag_t   out_tag;
	seq_t   out_seq;

	// accepted payloads in send order
	value_t sent_values[$];
	tag_t   sent_tags[$];

	int pair_count = 0;
	int cycle_count = 0;
	int value_errors = 0;
	int tag_errors = 0;
	int seq_errors = 0;
	int other_errors = 0;
	int assert_errors;

	// longest run of clk cycles with value_ready low
	int value_low_run = 0;
	int value_low_max = 0;

	int unsigned seed_ret;

	cdc_bridge_top i_cdc_bridge_top (
		.clk         (clk),
		.dst_clk     (dst_clk),
		.arst_n      (arst_n),
		.value_stb   (value_stb),
		.value       (value),
		.tag_stb     (tag_stb),
		.tag         (tag),
		.value_ready (value_ready),
		.tag_ready   (tag_ready),
		.out_stb     (out_stb),
		.out_value   (out_value),
		.out_tag     (out_tag),
		.out_seq     (out_seq)
	);

	always #(clk_half) clk = ~clk;

	always #(dst_clk_half) dst_clk = ~dst_clk;

	// expected contents of pair idx, straight from the send order
	function automatic void expected_pair(
		input  int     idx,
		input  value_t values_q[$],
		input  tag_t   tags_q[$],
		output value_t exp_value,
		output tag_t   exp_tag,
		output seq_t   exp_seq
	);
		exp_value = values_q[idx];
		exp_tag   = tags_q[idx];
		// sequence wraps at 2**SEQ_BITS
		exp_seq   = seq_t'(idx % (1 << SEQ_BITS));
	endfunction

	task automatic check_value(input string name, input value_t expected, input value_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			tag_errors++;
		end
	endtask

	task automatic check_seq(input string name, input seq_t expected, input seq_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			seq_errors++;
		end
	endtask

	// value channel sends in bursts, gap of at most one cycle
	task automatic send_values();
		int n;
		int gap;
		for (n = 0; n < num_pairs; n++) begin
			while (!value_ready) begin
				@(negedge clk);
			end
			value_stb = 1'b1;
			value = value_t'($urandom);
			sent_values.push_back(value);
			@(negedge clk);
			value_stb = 1'b0;
			// req toggled on the accepting edge
			if (value_ready) begin
				$display("value_ready still high one cycle after accepted value %0d", n);
				other_errors++;
			end
			gap = $urandom_range(1, 0);
			repeat (gap) @(negedge clk);
		end
	endtask

	// tag channel is slow, long gaps between sends
	task automatic send_tags();
		int n;
		int gap;
		for (n = 0; n < num_pairs; n++) begin
			while (!tag_ready) begin
				@(negedge clk);
			end
			tag_stb = 1'b1;
			tag = tag_t'($urandom);
			sent_tags.push_back(tag);
			@(negedge clk);
			tag_stb = 1'b0;
			if (tag_ready) begin
				$display("tag_ready still high one cycle after accepted tag %0d", n);
				other_errors++;
			end
			gap = $urandom_range(14, 4);
			repeat (gap) @(negedge clk);
		end
	endtask

	// outputs sampled mid-cycle of dst_clk, where they are settled
	always @(negedge dst_clk) begin : compare_pairs
		value_t exp_value;
		tag_t   exp_tag;
		seq_t   exp_seq;
		if (out_stb) begin
			if (pair_count >= sent_values.size() || pair_count >= sent_tags.size()) begin
				$display("unexpected pair %0d: output strobe without a sent value and tag",
					pair_count);
				other_errors++;
			end else begin
				expected_pair(pair_count, sent_values, sent_tags, exp_value, exp_tag, exp_seq);
				check_value($sformatf("pair %0d value", pair_count), exp_value, out_value);
				check_tag($sformatf("pair %0d tag", pair_count), exp_tag, out_tag);
				check_seq($sformatf("pair %0d seq", pair_count), exp_seq, out_seq);
			end
			pair_count++;
		end
	end

	// back-pressure shows up as long stretches of value_ready low
	always @(negedge clk) begin
		if (arst_n && !value_ready) begin
			value_low_run++;
			if (value_low_run > value_low_max) begin
				value_low_max = value_low_run;
			end
		end else begin
			value_low_run = 0;
		end
	end

	initial begin : watchdog
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d clk cycles, %0d of %0d pairs received",
			cycle_count, pair_count, num_pairs);
		$display("** FAIL **");
		$finish;
	end

	initial begin : main
		int wait_cycles;
		seed_ret = $urandom(rand_seed);
		clk = 1'b0;
		dst_clk = 1'b0;
		arst_n = 1'b0;
		value_stb = 1'b0;
		value = '0;
		tag_stb = 1'b0;
		tag = '0;

		repeat (reset_cycles) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		if (!value_ready || !tag_ready) begin
			$display("ready low after reset: value_ready %b, tag_ready %b",
				value_ready, tag_ready);
			other_errors++;
		end

		fork
			send_values();
			send_tags();
		join

		// let the last pairs cross and come out
		wait_cycles = 0;
		while (pair_count < num_pairs && wait_cycles < drain_cycles) begin
			@(negedge clk);
			wait_cycles++;
		end
		repeat (10) @(negedge clk);

		if (pair_count < num_pairs) begin
			$display("missing pairs: only %0d of %0d came out", pair_count, num_pairs);
			other_errors++;
		end
		if (value_low_max <= free_stall_max) begin
			$display("value channel never stalled, longest ready low run %0d cycles",
				value_low_max);
			other_errors++;
		end

		assert_errors = i_cdc_bridge_top.i_value_import.i_import_props.assert_failures
			+ i_cdc_bridge_top.i_tag_import.i_import_props.assert_failures;

		$display("errors: value %0d, tag %0d, seq %0d, other %0d, assertion %0d over %0d pairs",
			value_errors, tag_errors, seq_errors, other_errors, assert_errors, pair_count);
		if (value_errors + tag_errors + seq_errors + other_errors + assert_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: sources.f
design/cdc_pkg.sv
design/cdc_export.sv
design/cdc_import.sv
design/pair_merge.sv
design/cdc_bridge_top.sv
tests/cdc_import_props.sv
tests/cdc_bridge_tb.sv
